//--- verilog.f
+incdir+src
src/gtp_test_pkg.sv
src/seq_if.sv
src/reset_sequencer.sv
src/prbs_gen.sv
src/tx_word_source.sv
src/led_status.sv
src/gtp_test_top.sv
verification/gtp_test_asserts.sv
verification/gtp_test_tb.sv

//--- Makefile
TOP := gtp_test_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@grep -qx "Test completed successfully" sim.log || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf obj_dir sim.log

//--- verification/gtp_test_tb.sv
`include "gtp_test_defs.svh"

module gtp_test_tb
	import gtp_test_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_PH   = 8;
	localparam int GEN_REL  = 1 << `GTP_RST_PICK;       // Edge where gen_rst falls
	localparam int TX_REL   = 1 << (`GTP_RST_PICK + 1); // Edge where tx_rst falls
	localparam int READY_AT = 1 << (`GTP_RST_PICK + 2); // Edge where tx_ready rises
	localparam int BRINGUP  = READY_AT + 2;

	logic        gt1_txusrclk2_i = 1'b0;
	logic        rst_n           = 1'b0;
	logic [1:0]  pattern_sel     = 2'd0;
	logic        inject_err      = 1'b0;
	logic [15:0] txdata;
	logic [1:0]  txcharisk;
	logic        tx_ready;
	logic [3:0]  led;

	int cyc         = 0; // Edges since rst_n release
	int checks      = 0;
	int data_errs   = 0;
	int status_errs = 0;
	int injects     = 0;

	// Phase table
	// Mode, length in cycles, random inject pulses, expected word and charisk
	// The word column is only used by idle and square
	pattern_e    ph_sel     [NUM_PH] = '{PAT_COUNT, PAT_PRBS, PAT_IDLE, PAT_SQUARE,
	                                     PAT_PRBS, PAT_COUNT, PAT_SQUARE, PAT_PRBS};
	int          ph_cycles  [NUM_PH] = '{200, 300, 60, 60, 40, 100, 60, 1200};
	bit          ph_inject  [NUM_PH] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
	logic [15:0] ph_word    [NUM_PH] = '{16'h0000, 16'h0000, 16'h50BC, 16'hFF00,
	                                     16'h0000, 16'h0000, 16'hFF00, 16'h0000};
	logic [1:0]  ph_charisk [NUM_PH] = '{2'b00, 2'b00, 2'b01, 2'b00,
	                                     2'b00, 2'b00, 2'b00, 2'b00};

	always #20 gt1_txusrclk2_i = ~gt1_txusrclk2_i;

	gtp_test_top dut (
		.gt1_txusrclk2_i (gt1_txusrclk2_i),
		.rst_n           (rst_n),
		.pattern_sel     (pattern_sel),
		.inject_err      (inject_err),
		.txdata          (txdata),
		.txcharisk       (txcharisk),
		.tx_ready        (tx_ready),
		.led             (led)
	);

	// Next 16 bits of x^15 + x^14 + 1 given the previous word
	function automatic logic [15:0] prbs_next(input logic [15:0] prev);
		logic [30:0] bits;
		bits        = '0;
		bits[30:16] = prev[14:0]; // Oldest bit at the top
		for (int j = 15; j >= 0; j--) begin
			bits[j] = bits[j + 15] ^ bits[j + 14];
		end
		return bits[15:0];
	endfunction

	function automatic int total_cycles();
		int sum;
		sum = 0;
		for (int p = 0; p < NUM_PH; p++) begin
			sum += ph_cycles[p];
		end
		return sum;
	endfunction

	// Outputs are settled 2 ns after the edge
	task automatic tick();
		@(posedge gt1_txusrclk2_i);
		#2;
		cyc++;
	endtask

	task automatic check_charisk(input logic [1:0] exp_k);
		checks++;
		if (txcharisk !== exp_k) begin
			data_errs++;
			$display("Fail txcharisk: got 0x%h, expected 0x%h at cycle %0d",
				txcharisk, exp_k, cyc);
		end
	endtask

	task automatic check_word(input logic [15:0] exp, input logic [1:0] exp_k);
		checks++;
		if (txdata !== exp) begin
			data_errs++;
			$display("Fail txdata: got 0x%h, expected 0x%h at cycle %0d", txdata, exp, cyc);
		end
		check_charisk(exp_k);
	endtask

	task automatic check_status(input pattern_e sel, input logic exp_ready,
		input logic exp_led0);
		logic [3:0] exp_led;
		int         beats;
		beats      = cyc - 1; // Heartbeat count before this edge
		exp_led[0] = exp_led0;
		exp_led[1] = (sel == PAT_PRBS);
		exp_led[2] = (sel == PAT_IDLE);
		exp_led[3] = beats[`GTP_HEARTBEAT_BIT];
		checks++;
		if (tx_ready !== exp_ready) begin
			status_errs++;
			$display("Fail tx_ready: got 0x%h, expected 0x%h at cycle %0d",
				tx_ready, exp_ready, cyc);
		end
		if (led !== exp_led) begin
			status_errs++;
			$display("Fail led: got 0x%h, expected 0x%h at cycle %0d", led, exp_led, cyc);
		end
	endtask

	// Stages released by edge k after rst_n release
	task automatic check_stage(input int k);
		logic [1:0] exp_stage;
		exp_stage = 2'd0;
		if (k >= READY_AT) begin
			exp_stage = 2'd3;
		end else if (k >= TX_REL) begin
			exp_stage = 2'd2;
		end else if (k >= GEN_REL) begin
			exp_stage = 2'd1;
		end
		checks++;
		if (dut.seq.stage !== exp_stage) begin
			status_errs++;
			$display("Fail stage: got 0x%h, expected 0x%h at cycle %0d",
				dut.seq.stage, exp_stage, cyc);
		end
	endtask

	initial begin
		logic        inj;
		logic [15:0] model;
		inj   = 1'b0;
		model = '0;
		void'($urandom(32'hb9ff_77e2));

		repeat (2) @(posedge gt1_txusrclk2_i);
		#2;
		check_word(16'h50BC, 2'b01); // Idle word held in reset
		if (tx_ready !== 1'b0) begin
			status_errs++;
			$display("Fail tx_ready: got 0x%h, expected 0x0 during reset", tx_ready);
		end
		rst_n = 1'b1;

		// Counter selected during bring-up but the idle word holds until tx_ready
		for (int k = 1; k <= BRINGUP; k++) begin
			tick();
			if (k <= READY_AT) begin
				check_word(16'h50BC, 2'b01);
			end else begin
				check_charisk(2'b00);
			end
			check_status(PAT_COUNT, k >= READY_AT, k > READY_AT);
			check_stage(k);
		end

		for (int p = 0; p < NUM_PH; p++) begin
			for (int i = 0; i < ph_cycles[p]; i++) begin
				// No pulse on the word that seeds a model
				inj         = ph_inject[p] && (i > 0) && ($urandom_range(0, 11) == 0);
				pattern_sel = ph_sel[p];
				inject_err  = inj;
				if (inj) begin
					injects++;
				end
				tick();
				check_status(ph_sel[p], 1'b1, 1'b1);
				case (ph_sel[p])
					PAT_COUNT, PAT_PRBS: begin
						if (i == 0) begin
							model = txdata;
							check_charisk(2'b00);
						end else begin
							model = (ph_sel[p] == PAT_COUNT) ? model + 16'd1 : prbs_next(model);
							check_word(model ^ {15'd0, inj}, 2'b00);
						end
					end
					PAT_IDLE: begin
						check_word(ph_word[p], ph_charisk[p]); // Commas never corrupted
					end
					default: begin
						check_word(ph_word[p] ^ {15'd0, inj}, ph_charisk[p]);
					end
				endcase
			end
		end
		inject_err = 1'b0;

		if (injects == 0) begin
			status_errs++;
			$display("No inject_err pulse was generated during the run");
		end

		$display("Checks %0d, injects %0d, errors data %0d, status %0d, assertion %0d",
			checks, injects, data_errs, status_errs, dut.u_asserts.fail_count);
		if (data_errs + status_errs + dut.u_asserts.fail_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Watchdog
	initial begin : watchdog
		int limit_ns;
		limit_ns = (total_cycles() + 64) * 40 + 4000; // Margin for reset and tail
		#(limit_ns);
		$display("Timeout, the run did not finish within %0d ns", limit_ns);
		$display("Test failed");
		$finish;
	end

endmodule

//--- verification/gtp_test_asserts.sv
module gtp_test_asserts
	import gtp_test_pkg::*;
(
	input logic        clk,
	input logic        rst_n,
	input logic        gen_rst,
	input logic        tx_rst,
	input logic        tx_ready,
	input logic [15:0] txdata,
	input logic [1:0]  txcharisk
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0; // Failed assertions so far

	// Lane ready is sticky until the next reset
	ready_sticky: assert property (
		@(posedge clk) disable iff (!rst_n) tx_ready |=> tx_ready
	) else begin
		fail_count++;
		$error("tx_ready dropped while rst_n was high");
	end

	// Only the idle word carries a K character
	charisk_idle: assert property (
		@(posedge clk) (txcharisk != CHARISK_DATA) |->
			(txdata == {D16_2, K28_5} && txcharisk == CHARISK_IDLE)
	) else begin
		fail_count++;
		$error("txcharisk set on a word other than the idle word");
	end

	release_order: assert property (
		@(posedge clk) disable iff (!rst_n) !tx_rst |-> !gen_rst
	) else begin
		fail_count++;
		$error("tx_rst released while gen_rst still held");
	end

endmodule

bind gtp_test_top gtp_test_asserts u_asserts (
	.clk       (gt1_txusrclk2_i),
	.rst_n     (rst_n),
	.gen_rst   (seq.gen_rst),
	.tx_rst    (seq.tx_rst),
	.tx_ready  (tx_ready),
	.txdata    (txdata),
	.txcharisk (txcharisk)
);

//--- src/gtp_test_top.sv
`include "gtp_test_defs.svh"

module gtp_test_top
	import gtp_test_pkg::*;
(
	input  logic                   gt1_txusrclk2_i,
	input  logic                   rst_n,
	input  logic [1:0]             pattern_sel,
	input  logic                   inject_err,   // One-cycle pulse
	output logic [`GTP_WORD_W-1:0] txdata,
	output logic [1:0]             txcharisk,
	output logic                   tx_ready,
	output logic [`GTP_LED_W-1:0]  led
);

	pattern_e mode;
	tx_word_u tx_word;

	seq_if seq ();

	assign mode     = pattern_e'(pattern_sel);
	assign txdata   = tx_word.raw;
	assign tx_ready = seq.tx_ready;

	// Staged release after rst_n
	reset_sequencer u_seq (
		.gt1_txusrclk2_i (gt1_txusrclk2_i),
		.rst_n           (rst_n),
		.seq             (seq)
	);

	// Word and charisk to the transceiver
	tx_word_source u_src (
		.gt1_txusrclk2_i (gt1_txusrclk2_i),
		.rst_n           (rst_n),
		.seq             (seq),
		.pattern_sel     (mode),
		.inject_err      (inject_err),
		.txdata          (tx_word),
		.txcharisk       (txcharisk)
	);

	led_status u_led (
		.gt1_txusrclk2_i (gt1_txusrclk2_i),
		.rst_n           (rst_n),
		.seq             (seq),
		.pattern_sel     (mode),
		.led             (led)
	);

endmodule

//--- src/led_status.sv
`include "gtp_test_defs.svh"

module led_status
	import gtp_test_pkg::*;
(
	input  logic                  gt1_txusrclk2_i,
	input  logic                  rst_n,
	seq_if.user                   seq,
	input  pattern_e              pattern_sel,
	output logic [`GTP_LED_W-1:0] led
);

	logic [`GTP_HEARTBEAT_BIT:0] beat; // Free-running, wraps

	always_ff @(posedge gt1_txusrclk2_i or negedge rst_n) begin
		if (!rst_n) begin
			beat <= '0;
		end else begin
			beat <= beat + 1'b1;
		end
	end

	// LED map
	// 0 lane ready, 1 PRBS, 2 idle, 3 heartbeat
	always_ff @(posedge gt1_txusrclk2_i or negedge rst_n) begin
		if (!rst_n) begin
			led <= '0;
		end else begin
			led[0] <= seq.tx_ready;
			led[1] <= (pattern_sel == PAT_PRBS);
			led[2] <= (pattern_sel == PAT_IDLE);
			led[3] <= beat[`GTP_HEARTBEAT_BIT];
		end
	end

endmodule

//--- src/tx_word_source.sv
module tx_word_source
	import gtp_test_pkg::*;
(
	input  logic       gt1_txusrclk2_i,
	input  logic       rst_n,
	seq_if.user        seq,
	input  pattern_e   pattern_sel,
	input  logic       inject_err,
	output tx_word_u   txdata,
	output logic [1:0] txcharisk
);

	logic [15:0] count;
	logic [15:0] prbs_word;
	tx_word_u    idle_word;
	tx_word_u    pat_word; // Selected pattern before forcing
	tx_word_u    word_nxt;
	logic        idle_nxt;

	prbs_gen u_prbs (
		.gt1_txusrclk2_i (gt1_txusrclk2_i),
		.rst_n           (rst_n),
		.seq             (seq),
		.prbs_word       (prbs_word)
	);

	// Counter pattern, runs in every mode
	always_ff @(posedge gt1_txusrclk2_i or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (seq.gen_rst) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// Comma in the low byte so it goes out first
	assign idle_word.bytes = '{byte_hi: D16_2, byte_lo: K28_5};

	always_comb begin
		pat_word.raw = '0;
		case (pattern_sel)
			PAT_COUNT: begin
				pat_word.raw = count;
			end
			PAT_PRBS: begin
				pat_word.raw = prbs_word;
			end
			PAT_IDLE: begin
				pat_word = idle_word;
			end
			PAT_SQUARE: begin
				pat_word.bytes = '{byte_hi: 8'hFF, byte_lo: 8'h00}; // Low-rate square wave
			end
		endcase
	end

	// Idle until the lane is ready, then the chosen pattern
	always_comb begin
		idle_nxt = seq.tx_rst || !seq.tx_ready || (pattern_sel == PAT_IDLE);
		word_nxt = pat_word;
		if (seq.tx_rst || !seq.tx_ready) begin
			word_nxt = idle_word;
		end
		// Commas stay clean so the receiver keeps alignment
		if (inject_err && !idle_nxt) begin
			word_nxt.raw[0] = ~word_nxt.raw[0];
		end
	end

	always_ff @(posedge gt1_txusrclk2_i or negedge rst_n) begin
		if (!rst_n) begin
			txdata.raw <= {D16_2, K28_5};
			txcharisk  <= CHARISK_IDLE;
		end else begin
			txdata    <= word_nxt;
			txcharisk <= idle_nxt ? CHARISK_IDLE : CHARISK_DATA;
		end
	end

endmodule

//--- src/prbs_gen.sv
`include "gtp_test_defs.svh"

module prbs_gen (
	input  logic        gt1_txusrclk2_i,
	input  logic        rst_n,
	seq_if.user         seq,
	output logic [15:0] prbs_word
);

	logic [14:0] lfsr;      // Last 15 bits sent
	logic [14:0] lfsr_next;

	// Sixteen serial steps of x^15 + x^14 + 1 unrolled into one clock
	// The first new bit lands in the MSB of the word
	always_comb begin : step_blk
		logic [14:0] s;
		logic        fb;
		s         = lfsr;
		fb        = 1'b0;
		prbs_word = '0;
		for (int i = 15; i >= 0; i--) begin
			fb           = s[14] ^ s[13];
			prbs_word[i] = fb;
			s            = {s[13:0], fb};
		end
		lfsr_next = s;
	end

	always_ff @(posedge gt1_txusrclk2_i or negedge rst_n) begin
		if (!rst_n) begin
			lfsr <= `GTP_PRBS_SEED;
		end else if (seq.gen_rst) begin
			lfsr <= `GTP_PRBS_SEED; // Reload until the generators are let go
		end else begin
			lfsr <= lfsr_next;
		end
	end

endmodule

//--- src/reset_sequencer.sv
`include "gtp_test_defs.svh"

module reset_sequencer (
	input  logic gt1_txusrclk2_i,
	input  logic rst_n,
	seq_if.seq   seq
);

	localparam int CNT_W = `GTP_RST_PICK + 3; // Top bit marks the last stage

	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_inc;
	logic             gen_rst_q;
	logic             tx_rst_q;
	logic             tx_ready_q;

	// Value the counter takes at this edge
	assign cnt_inc = cnt + 1'b1;

	// Pick-off counter, parks once the top bit is set
	always_ff @(posedge gt1_txusrclk2_i or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (!cnt[CNT_W-1]) begin
			cnt <= cnt_inc;
		end
	end

	// Each stage lets go on its counter bit and stays released
	always_ff @(posedge gt1_txusrclk2_i or negedge rst_n) begin
		if (!rst_n) begin
			gen_rst_q  <= 1'b1;
			tx_rst_q   <= 1'b1;
			tx_ready_q <= 1'b0;
		end else begin
			if (cnt_inc[`GTP_RST_PICK]) begin
				gen_rst_q <= 1'b0;
			end
			if (cnt_inc[`GTP_RST_PICK + 1]) begin
				tx_rst_q <= 1'b0;
			end
			if (cnt_inc[`GTP_RST_PICK + 2]) begin
				tx_ready_q <= 1'b1;
			end
		end
	end

	// Stage count from the sticky flags
	always_comb begin
		if (tx_ready_q) begin
			seq.stage = 2'd3;
		end else if (!tx_rst_q) begin
			seq.stage = 2'd2;
		end else if (!gen_rst_q) begin
			seq.stage = 2'd1;
		end else begin
			seq.stage = 2'd0;
		end
	end

	assign seq.gen_rst  = gen_rst_q;
	assign seq.tx_rst   = tx_rst_q;
	assign seq.tx_ready = tx_ready_q;

endmodule

//--- src/seq_if.sv
interface seq_if;

	logic       gen_rst;  // Holds pattern generators
	logic       tx_rst;   // Forces the idle word
	logic       tx_ready; // Lane in data mode
	logic [1:0] stage;    // Stages released so far

	modport seq (
		output gen_rst,
		output tx_rst,
		output tx_ready,
		output stage
	);

	modport user (
		input gen_rst,
		input tx_rst,
		input tx_ready,
		input stage
	);

endinterface

//--- src/gtp_test_pkg.sv
package gtp_test_pkg;

	// Transmit pattern select
	typedef enum logic [1:0] {
		PAT_COUNT  = 2'd0,
		PAT_PRBS   = 2'd1,
		PAT_IDLE   = 2'd2,
		PAT_SQUARE = 2'd3
	} pattern_e;

	typedef struct packed {
		logic [7:0] byte_hi;
		logic [7:0] byte_lo; // Goes out first on the lane
	} tx_bytes_t;

	// One transmit word, seen whole or as two 8b10b characters
	typedef union packed {
		logic [15:0] raw;
		tx_bytes_t   bytes;
	} tx_word_u;

	localparam logic [7:0] K28_5 = 8'hBC; // Comma
	localparam logic [7:0] D16_2 = 8'h50; // Idle filler

	// Charisk marks the comma byte only
	localparam logic [1:0] CHARISK_IDLE = 2'b01;
	localparam logic [1:0] CHARISK_DATA = 2'b00;

endpackage

//--- src/gtp_test_defs.svh
`ifndef GTP_TEST_DEFS_SVH
`define GTP_TEST_DEFS_SVH

// Counter bit that releases the first reset stage
// Later stages follow at the next two bits up
`define GTP_RST_PICK 4

// Heartbeat LED toggles every 2^N cycles
`define GTP_HEARTBEAT_BIT 10

// PRBS-15 start value, must not be zero
`define GTP_PRBS_SEED 15'h7FFF

// Lane word width
`define GTP_WORD_W 16

// Number of LEDs on the board
`define GTP_LED_W 4

`endif
